//--- design/cmd_deser.sv
// byte-serial command deserializer decoding rtc register writes
`timescale 1ns/1ps

module cmd_deser (
    input  logic              rst,
    input  logic              mclk,
    input  logic [7:0]        cmd_ad,
    input  logic              cmd_stb,
    output rtc_pkg::rtc_cmd_t cmd
);
    import rtc_pkg::*;

    logic [2:0]  byte_cnt;      // 0 idle, 1..5 bytes already taken
    logic [39:0] sr;            // AL AH D0 D1 D2, oldest in low byte
    logic [47:0] frame;         // stored bytes plus D3 on the bus
    logic        last;          // sixth byte present
    logic        addr_hit;
    logic        sel_ok;
    logic        we_q;
    rtc_reg_e    sel_q;
    logic [31:0] data_q;

    assign frame    = {cmd_ad, sr};
    assign last     = (byte_cnt == 3'd5);
    assign addr_hit = (frame[15:3] == cmd_addr_base[15:3]);   // base match only
    assign sel_ok   = (frame[2:0] <= 3'(reg_set_corr));       // reject unused selects

    // frame position counter, stb marks byte 0
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= '0;
        end else if (cmd_stb) begin
            byte_cnt <= 3'd1;
        end else if (last) begin
            byte_cnt <= '0;             // frame done
        end else if (byte_cnt != '0) begin
            byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // shift bytes in from the top
    always_ff @(posedge mclk) begin
        if (cmd_stb || (byte_cnt != '0)) begin
            sr <= {cmd_ad, sr[39:8]};
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            we_q <= 1'b0;
        end else begin
            we_q <= last && addr_hit && sel_ok;     // single cycle pulse
        end
    end

    always_ff @(posedge mclk) begin
        if (last) begin
            sel_q  <= rtc_reg_e'(frame[2:0]);
            data_q <= frame[47:16];             // D0 is the low byte
        end
    end

    assign cmd = '{sel: sel_q, data: data_q, we: we_q};

endmodule

//--- design/event_stamper.sv
// event synchronizer, time capture, single pending stamp and credit counter for one channel
`timescale 1ns/1ps

module event_stamper #(
    parameter int chan_id = 0
) (
    input  logic               rst,
    input  logic               mclk,
    input  logic               event_in,       // async to mclk
    input  rtc_pkg::rtc_time_t now,
    input  logic               credit_ret,
    output logic               stamp_valid,
    output rtc_pkg::stamp_t    stamp
);
    import rtc_pkg::*;

    logic [1:0]           ev_sync;
    logic                 ev_prev;
    logic                 ev_edge;        // 3 cycles after event
    logic                 capture;
    logic                 pending;
    logic                 lost;
    rtc_time_t            ts_q;
    logic [cred_bits-1:0] credits;
    logic                 send;

    assign send    = pending && (credits != '0);
    assign capture = ev_edge && (!pending || send);   // slot frees this cycle

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ev_sync <= '0;
            ev_prev <= 1'b0;
            ev_edge <= 1'b0;
            pending <= 1'b0;
            lost    <= 1'b0;
            credits <= cred_bits'(chan_credits);
        end else begin
            ev_sync <= {ev_sync[0], event_in};
            ev_prev <= ev_sync[1];
            ev_edge <= ev_sync[1] & ~ev_prev;
            if (capture) begin
                pending <= 1'b1;
                lost    <= 1'b0;    // new record starts clean
            end else if (ev_edge) begin
                lost    <= 1'b1;    // drop, mark held record
            end else if (send) begin
                pending <= 1'b0;
                lost    <= 1'b0;
            end
            case ({send, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (capture) ts_q <= now;
    end

    assign stamp_valid = send;
    assign stamp       = '{chan: chan_bits'(chan_id), lost: lost, ts: ts_q};

endmodule

//--- design/rtc_core.sv
// adjustable rtc with refclk sampling, prescaler, correction accumulator and sec/usec counters
`timescale 1ns/1ps

module rtc_core (
    input  logic               rst,
    input  logic               mclk,
    input  logic               refclk,     // slow, sampled in mclk domain
    input  rtc_pkg::rtc_cmd_t  cmd,
    output rtc_pkg::rtc_time_t now
);
    import rtc_pkg::*;

    logic                   set_usec_w;
    logic                   set_sec_w;
    logic                   set_corr_w;
    logic [19:0]            wusec;          // usec preset
    logic [31:0]            wsec;           // sec preset
    logic [15:0]            corr;           // signed trim
    logic                   enable_rtc;
    logic                   pend_load;      // seconds written, waiting for phase 3
    logic                   set_cntr;       // held for a whole half usec
    logic [2:0]             ref_s;
    logic                   ref2x;          // one pulse per refclk edge
    logic [prediv_bits-1:0] pre_cntr;
    logic                   pre_tick;
    logic [3:0]             halfusec;       // one-hot phase ring
    logic [23:0]            acc;
    logic [24:0]            next_acc;
    logic [1:0]             inc_usec;
    logic [1:0]             inc_sec;
    logic [19:0]            usec;
    logic [31:0]            sec;
    logic [19:0]            usec_plus1;
    logic [31:0]            sec_plus1;

    assign set_usec_w = cmd.we && (cmd.sel == reg_set_usec);
    assign set_sec_w  = cmd.we && (cmd.sel == reg_set_sec);
    assign set_corr_w = cmd.we && (cmd.sel == reg_set_corr);

    // half scale plus sign-extended correction, carry every 2 half usec at corr 0
    assign next_acc = {1'b0, acc} + {1'b0, ~corr[15], {7{corr[15]}}, corr};

    // count rtc_mhz-2 down through all ones, 25 edges per half usec
    assign pre_tick = ref2x && (&pre_cntr);

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wusec <= '0;
            wsec  <= '0;
            corr  <= '0;
        end else begin
            if (set_usec_w) wusec <= cmd.data[19:0];
            if (set_sec_w)  wsec  <= cmd.data;
            if (set_corr_w) corr  <= cmd.data[15:0];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            enable_rtc <= 1'b0;
            pend_load  <= 1'b0;
            set_cntr   <= 1'b0;
            ref_s      <= '0;
            ref2x      <= 1'b0;
            pre_cntr   <= prediv_bits'(rtc_mhz - 2);
            halfusec   <= '0;
            acc        <= '0;
            inc_usec   <= '0;
            inc_sec    <= '0;
        end else begin
            if (set_sec_w) enable_rtc <= 1'b1;      // runs from first seconds write

            if (set_sec_w)        pend_load <= 1'b1;
            else if (halfusec[3]) pend_load <= 1'b0;

            if (!enable_rtc)      set_cntr <= 1'b0;
            else if (halfusec[3]) set_cntr <= pend_load;

            ref_s <= {ref_s[1:0], refclk};
            ref2x <= ref_s[2] ^ ref_s[1];           // both edges

            if (!enable_rtc || pre_tick) pre_cntr <= prediv_bits'(rtc_mhz - 2);
            else if (ref2x)              pre_cntr <= pre_cntr - 1'b1;

            if (!enable_rtc) halfusec <= '0;
            else             halfusec <= {halfusec[2:0], pre_tick};

            if (halfusec[1]) acc <= set_cntr ? '0 : next_acc[23:0];   // load restarts phase

            // carry request, then registered adders, then counter update
            inc_usec <= {inc_usec[0], halfusec[1] & next_acc[24]};
            inc_sec  <= {inc_sec[0], halfusec[1] & next_acc[24] & (usec == 20'(usec_max))};
        end
    end

    always_ff @(posedge mclk) begin
        usec_plus1 <= usec + 20'd1;
        sec_plus1  <= sec + 32'd1;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            usec <= '0;
            sec  <= '0;
        end else if (set_cntr) begin
            usec <= wusec;
            sec  <= wsec;
        end else if (inc_sec[1]) begin
            usec <= '0;                 // rollover
            sec  <= sec_plus1;
        end else if (inc_usec[1]) begin
            usec <= usec_plus1;
        end
    end

    assign now = '{sec: sec, usec: usec};

    a_usec_range: assert property (@(posedge mclk) disable iff (rst)
        usec <= 20'(usec_max));

endmodule

//--- design/rtc_pkg.sv
// shared localparams, register select enum and time/stamp/command structs of the rtc subsystem
package rtc_pkg;

    localparam int          rtc_mhz       = 25;         // refclk frequency, whole MHz
    localparam int          prediv_bits   = 5;          // prescaler width
    localparam int          usec_max      = 999999;     // last usec before rollover
    localparam logic [15:0] cmd_addr_base = 16'h0170;   // upper 13 bits decoded
    localparam int          num_chan      = 4;          // stamper channels
    localparam int          chan_bits     = 2;          // channel tag width
    localparam int          chan_credits  = 2;          // merger buffer depth per channel
    localparam int          out_credits   = 4;          // sink buffer depth

    // counter and pointer widths derived from the depths above
    localparam int cred_bits  = $clog2(chan_credits + 1);
    localparam int ocred_bits = $clog2(out_credits + 1);
    localparam int fptr_bits  = (chan_credits > 1) ? $clog2(chan_credits) : 1;

    // low three address bits select the register
    typedef enum logic [2:0] {
        reg_set_usec = 3'd0,    // usec preset
        reg_set_sec  = 3'd1,    // sec preset, also loads and starts
        reg_set_corr = 3'd2     // signed rate correction
    } rtc_reg_e;

    typedef struct packed {
        rtc_reg_e    sel;
        logic [31:0] data;
        logic        we;        // one-cycle write strobe
    } rtc_cmd_t;

    typedef struct packed {
        logic [31:0] sec;
        logic [19:0] usec;
    } rtc_time_t;

    // ts stands for the captured time
    typedef struct packed {
        logic [chan_bits-1:0] chan;
        logic                 lost;     // an event after this one was dropped
        rtc_time_t            ts;
    } stamp_t;

endpackage

//--- design/rtc_subsys_top.sv
// timestamping subsystem top with command deserializer, rtc, stamper channels and merger
`timescale 1ns/1ps

module rtc_subsys_top (
    input  logic                         rst,
    input  logic                         mclk,
    input  logic                         refclk,
    input  logic [7:0]                   cmd_ad,
    input  logic                         cmd_stb,
    input  logic [rtc_pkg::num_chan-1:0] event_in,
    input  logic                         out_credit,
    output logic                         out_valid,
    output rtc_pkg::stamp_t              out_stamp,
    output rtc_pkg::rtc_time_t           now           // live time, for the testbench
);
    import rtc_pkg::*;

    rtc_cmd_t            cmd;               // decoded register write
    logic [num_chan-1:0] stamp_valid;
    stamp_t              stamp [num_chan];
    logic [num_chan-1:0] credit_ret;

    cmd_deser u_cmd_deser (
        .rst     (rst),
        .mclk    (mclk),
        .cmd_ad  (cmd_ad),
        .cmd_stb (cmd_stb),
        .cmd     (cmd)
    );

    rtc_core u_rtc_core (
        .rst    (rst),
        .mclk   (mclk),
        .refclk (refclk),
        .cmd    (cmd),
        .now    (now)
    );

    // one stamper per event input, tagged with its index
    for (genvar g = 0; g < num_chan; g++) begin : g_stamper
        event_stamper #(
            .chan_id (g)
        ) u_stamper (
            .rst         (rst),
            .mclk        (mclk),
            .event_in    (event_in[g]),
            .now         (now),
            .credit_ret  (credit_ret[g]),
            .stamp_valid (stamp_valid[g]),
            .stamp       (stamp[g])
        );
    end

    stamp_merger u_merger (
        .rst         (rst),
        .mclk        (mclk),
        .stamp_valid (stamp_valid),
        .stamp_in    (stamp),
        .credit_ret  (credit_ret),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_stamp   (out_stamp)
    );

endmodule

//--- design/stamp_merger.sv
// per-channel stamp buffers, round-robin drain and output credit counter
`timescale 1ns/1ps

module stamp_merger (
    input  logic                         rst,
    input  logic                         mclk,
    input  logic [rtc_pkg::num_chan-1:0] stamp_valid,
    input  rtc_pkg::stamp_t              stamp_in [rtc_pkg::num_chan],
    output logic [rtc_pkg::num_chan-1:0] credit_ret,
    input  logic                         out_credit,     // one per record consumed
    output logic                         out_valid,
    output rtc_pkg::stamp_t              out_stamp
);
    import rtc_pkg::*;

    stamp_t                fifo_mem [num_chan][chan_credits];
    logic [fptr_bits-1:0]  wr_ptr   [num_chan];
    logic [fptr_bits-1:0]  rd_ptr   [num_chan];
    logic [cred_bits-1:0]  fill     [num_chan];
    logic [num_chan-1:0]   not_empty;
    logic [num_chan-1:0]   full;
    logic [chan_bits-1:0]  rr_ptr;          // last channel served
    logic [chan_bits-1:0]  pick;
    logic                  found;
    logic                  pop;
    logic [ocred_bits-1:0] ocred;

    function automatic logic [fptr_bits-1:0] next_ptr(input logic [fptr_bits-1:0] p);
        return (p == fptr_bits'(chan_credits - 1)) ? '0 : p + 1'b1;
    endfunction

    // search starts one past the last winner
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        pick  = rr_ptr;
        for (int c = 0; c < num_chan; c++) begin
            not_empty[c] = (fill[c] != '0);
            full[c]      = (fill[c] == cred_bits'(chan_credits));
        end
        for (int i = 1; i <= num_chan; i++) begin
            idx = (rr_ptr + i) % num_chan;
            if (!found && not_empty[idx]) begin
                found = 1'b1;
                pick  = chan_bits'(idx);
            end
        end
        pop        = found && (ocred != '0);    // sink must have room
        credit_ret = '0;
        if (pop) credit_ret[pick] = 1'b1;
    end

    assign out_valid = pop;
    assign out_stamp = fifo_mem[pick][rd_ptr[pick]];

    always_ff @(posedge mclk) begin
        for (int c = 0; c < num_chan; c++) begin
            if (stamp_valid[c]) fifo_mem[c][wr_ptr[c]] <= stamp_in[c];
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            for (int c = 0; c < num_chan; c++) begin
                wr_ptr[c] <= '0;
                rd_ptr[c] <= '0;
                fill[c]   <= '0;
            end
            rr_ptr <= chan_bits'(num_chan - 1);    // channel 0 goes first
            ocred  <= ocred_bits'(out_credits);
        end else begin
            for (int c = 0; c < num_chan; c++) begin
                if (stamp_valid[c]) wr_ptr[c] <= next_ptr(wr_ptr[c]);
                if (credit_ret[c])  rd_ptr[c] <= next_ptr(rd_ptr[c]);
                case ({stamp_valid[c], credit_ret[c]})
                    2'b10:   fill[c] <= fill[c] + 1'b1;
                    2'b01:   fill[c] <= fill[c] - 1'b1;
                    default: fill[c] <= fill[c];
                endcase
            end
            if (pop) rr_ptr <= pick;
            case ({pop, out_credit})
                2'b10:   ocred <= ocred - 1'b1;
                2'b01:   ocred <= ocred + 1'b1;
                default: ocred <= ocred;
            endcase
        end
    end

    // stamper credit accounting keeps every buffer from overflowing
    a_no_overflow: assert property (@(posedge mclk) disable iff (rst)
        (stamp_valid & full) == '0);

    // sink never returns more credits than it has slots
    a_ocred_max: assert property (@(posedge mclk) disable iff (rst)
        ocred <= ocred_bits'(out_credits));

endmodule

//--- verif/rtc_tb_tests.svh
// command host, event and wait helpers, directed tests from reset state to round-robin drain

task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
    logic [7:0] bytes [6];
    bytes = '{addr[7:0], addr[15:8], data[7:0], data[15:8], data[23:16], data[31:24]};
    for (int i = 0; i < 6; i++) begin
        next_cycle();
        cmd_stb = (i == 0);         // stb with first byte only
        cmd_ad  = bytes[i];
    end
    next_cycle();
    cmd_ad = '0;
    next_cycle();                   // write strobe cycle
endtask

task automatic fire_events(input logic [num_chan-1:0] mask, output rtc_time_t t_evt);
    next_cycle();
    event_in = event_in | mask;
    t_evt    = now;                 // lower bound for the stamp
    repeat (3) next_cycle();
    event_in = event_in & ~mask;
endtask

task automatic wait_records(input int n, input int limit, output int used);
    used = 0;
    while ((rx_q.size() < n) && (used < limit)) begin
        next_cycle();
        used++;
    end
    if (rx_q.size() < n) begin
        $display("ERROR at %0t: %0d of %0d records in %0d cycles", $time, rx_q.size(), n, limit);
        err_count++;
    end
endtask

task automatic await_load(input longint sec, input longint usec, input int limit);
    int n;
    n = 0;
    while (!((now.sec == sec) && (now.usec == usec)) && (n < limit)) begin
        next_cycle();
        n++;
    end
    if (n >= limit) begin
        $display("ERROR at %0t: time %0d.%06d not loaded in %0d cycles", $time, sec, usec, limit);
        err_count++;
    end
endtask

task automatic expect_idle(input int cycles);
    logic now_bad;
    logic valid_bad;
    now_bad   = 1'b0;
    valid_bad = 1'b0;
    for (int n = 0; n < cycles; n++) begin
        next_cycle();
        if ((now != '0) && !now_bad) begin
            report_mismatch("now", to_us(now), 0);
            now_bad = 1'b1;         // report once
        end
        if (out_valid && !valid_bad) begin
            report_mismatch("out_valid", out_valid, 0);
            valid_bad = 1'b1;
        end
    end
endtask

task automatic after_reset_idle();
    int start_errs;
    start_errs = err_count;
    expect_idle(500);                                   // 2 us
    send_cmd({cmd_addr_base[15:3] ^ 13'h0020, reg_set_sec}, 32'd77);   // foreign base
    expect_idle(500);
    close_test("after_reset", start_errs);
endtask

task automatic set_time_rollover();
    int        start_errs;
    int        n;
    rtc_time_t prev;
    longint    t0;
    start_errs = err_count;
    send_cmd(reg_addr(reg_set_usec), 32'd999997);
    send_cmd(reg_addr(reg_set_sec), 32'd1000);
    await_load(1000, 999997, 500);
    prev = now;
    n    = 0;
    while ((now.sec == 32'd1000) && (n < 2500)) begin
        next_cycle();
        n++;
        if ((now != prev) && (to_us(now) != to_us(prev) + 1)) begin
            report_mismatch("now", to_us(now), to_us(prev) + 1);  // single steps only
        end
        prev = now;
    end
    if (now.sec != 32'd1001) report_mismatch("now.sec", now.sec, 1001);
    if (now.usec != 20'd0) report_mismatch("now.usec", now.usec, 0);
    t0 = to_us(now);
    repeat (5000) next_cycle();                         // 20 us
    if ((to_us(now) - t0 < 19) || (to_us(now) - t0 > 21)) begin
        out_of_range("now advance", to_us(now) - t0, 19, 21);
    end
    close_test("set_time", start_errs);
endtask

task automatic measure_rate(input int corr_val, input int sec_val);
    longint t0;
    longint diff;
    int     exp;
    exp = $rtoi(2000.0 * (1.0 + corr_val / 8388608.0) + 0.5);  // 2000 us scaled by 1 + c/2^23
    send_cmd(reg_addr(reg_set_corr), 32'(corr_val));
    send_cmd(reg_addr(reg_set_usec), 32'd0);
    send_cmd(reg_addr(reg_set_sec), 32'(sec_val));
    await_load(sec_val, 0, 500);
    t0 = to_us(now);
    repeat (500000) next_cycle();                       // 2000 us of reference time
    diff = to_us(now) - t0;
    if ((diff < exp - 1) || (diff > exp + 1)) out_of_range("now advance", diff, exp - 1, exp + 1);
endtask

task automatic rate_correction();
    int start_errs;
    start_errs = err_count;
    measure_rate(32767, 2000);
    measure_rate(-32768, 3000);
    close_test("correction", start_errs);
endtask

task automatic event_stamping();
    int        start_errs;
    int        ch;
    int        gap;
    int        used;
    rtc_time_t t_lo;
    longint    t_hi;
    stamp_t    rec;
    start_errs = err_count;
    send_cmd(reg_addr(reg_set_corr), 32'd0);           // nominal rate
    rx_q.delete();
    for (int k = 0; k < 8; k++) begin
        take_bits(2, ch);
        take_bits(8, gap);
        fire_events(num_chan'(1 << ch), t_lo);
        wait_records(1, 200, used);
        repeat (246 - used) next_cycle();              // 1 us after the event
        t_hi = to_us(now);
        if (rx_q.size() == 1) begin
            rec = rx_q.pop_front();
            if (rec.chan != ch) report_mismatch("out_stamp.chan", rec.chan, ch);
            if (rec.lost) report_mismatch("out_stamp.lost", rec.lost, 0);
            if ((to_us(rec.ts) < to_us(t_lo)) || (to_us(rec.ts) > t_hi)) begin
                out_of_range("out_stamp.ts", to_us(rec.ts), to_us(t_lo), t_hi);
            end
        end else begin
            report_mismatch("record count", rx_q.size(), 1);
            rx_q.delete();
        end
        repeat (500 + gap) next_cycle();               // at least 2 us apart
    end
    close_test("stamping", start_errs);
endtask

task automatic sink_back_pressure();
    int        start_errs;
    int        used;
    int        n_kept;
    rtc_time_t t_evt;
    longint    t_fire [$];                             // now at each event
    stamp_t    rec;
    stamp_t    prev;
    start_errs = err_count;
    n_kept     = out_credits + chan_credits + 1;       // sink, buffer, pending
    rx_q.delete();
    hold_credit = 1'b1;
    for (int k = 0; k < n_kept + 1; k++) begin
        fire_events(num_chan'(2), t_evt);
        t_fire.push_back(to_us(t_evt));
        repeat (496) next_cycle();                     // 2 us per event
    end
    if (rx_q.size() != out_credits) begin
        report_mismatch("records while stalled", rx_q.size(), out_credits);
    end
    hold_credit = 1'b0;
    wait_records(n_kept, 300, used);
    repeat (100) next_cycle();                         // nothing more may follow
    if (rx_q.size() != n_kept) report_mismatch("records delivered", rx_q.size(), n_kept);
    prev = '0;
    for (int i = 0; i < rx_q.size(); i++) begin
        rec = rx_q[i];
        if (rec.chan != 1) report_mismatch("out_stamp.chan", rec.chan, 1);
        if (rec.lost != (i == n_kept - 1)) begin
            report_mismatch("out_stamp.lost", rec.lost, i == n_kept - 1);
        end
        if ((i < t_fire.size()) &&
            ((to_us(rec.ts) < t_fire[i]) || (to_us(rec.ts) > t_fire[i] + 1))) begin
            out_of_range("out_stamp.ts", to_us(rec.ts), t_fire[i], t_fire[i] + 1);
        end
        if ((i > 0) && (to_us(rec.ts) < to_us(prev.ts))) begin
            $display("CHECK FAILED at %0t: out_stamp.ts is %0d, expected at least %0d",
                     $time, to_us(rec.ts), to_us(prev.ts));
            err_count++;
        end
        prev = rec;
    end
    rx_q.delete();
    close_test("back_pressure", start_errs);
endtask

task automatic round_robin_drain();
    int                  start_errs;
    int                  used;
    logic [num_chan-1:0] seen;
    rtc_time_t           t_evt;
    stamp_t              rec;
    stamp_t              first;
    start_errs = err_count;
    seen       = '0;
    first      = '0;
    rx_q.delete();
    fire_events('1, t_evt);                            // all channels, same cycle
    wait_records(num_chan, 100, used);
    repeat (50) next_cycle();
    if (rx_q.size() != num_chan) report_mismatch("records delivered", rx_q.size(), num_chan);
    if (rx_q.size() > 0) first = rx_q[0];
    if ((to_us(first.ts) < to_us(t_evt)) || (to_us(first.ts) > to_us(t_evt) + 1)) begin
        out_of_range("out_stamp.ts", to_us(first.ts), to_us(t_evt), to_us(t_evt) + 1);
    end
    while (rx_q.size() > 0) begin
        rec = rx_q.pop_front();
        if (seen[rec.chan]) begin
            $display("ERROR at %0t: channel %0d delivered more than once", $time, rec.chan);
            err_count++;
        end
        seen[rec.chan] = 1'b1;
        if (rec.lost) report_mismatch("out_stamp.lost", rec.lost, 0);
        if (rec.ts != first.ts) report_mismatch("out_stamp.ts", to_us(rec.ts), to_us(first.ts));
    end
    if (seen != {num_chan{1'b1}}) report_mismatch("channels seen", seen, {num_chan{1'b1}});
    close_test("round_robin", start_errs);
endtask

//--- verif/rtc_tb.sv
// testbench top with clocks, reset, DUT, LFSR, sink model, check helpers, timeout and final report
`timescale 1ns/1ps

module rtc_tb;
    import rtc_pkg::*;

    // reset/idle, set time, two 2000 us rate runs, stamping, back-pressure, round-robin
    localparam int test_cycles    = 1500 + 8000 + 2 * (600 + 500000) + 9500 + 6000 + 1000;
    localparam int timeout_cycles = test_cycles + test_cycles / 10;

    logic                rst;
    logic                mclk;
    logic                refclk;
    logic [7:0]          cmd_ad;
    logic                cmd_stb;
    logic [num_chan-1:0] event_in;
    logic                out_credit;
    logic                out_valid;
    stamp_t              out_stamp;
    rtc_time_t           now;

    stamp_t      rx_q [$];          // records taken by the sink
    int          owed_credits;      // consumed, credit not yet returned
    logic        hold_credit;       // sink stalls while set
    logic [23:0] lfsr_state;
    int          err_count;
    int          test_count;
    int          failed_tests;
    int          cycle_cnt;

    rtc_subsys_top dut_i (
        .rst        (rst),
        .mclk       (mclk),
        .refclk     (refclk),
        .cmd_ad     (cmd_ad),
        .cmd_stb    (cmd_stb),
        .event_in   (event_in),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_stamp  (out_stamp),
        .now        (now)
    );

    always #2 mclk = ~mclk;         // 250 MHz
    always #20 refclk = ~refclk;    // 25 MHz reference

    // sink takes a record mid-cycle
    always @(negedge mclk) begin
        if (!rst && out_valid) begin
            rx_q.push_back(out_stamp);
            owed_credits++;
        end
    end

    // one credit back per cycle unless stalled
    always begin
        @(posedge mclk);
        #1;
        if (!hold_credit && (owed_credits > 0)) begin
            out_credit = 1'b1;
            owed_credits--;
        end else begin
            out_credit = 1'b0;
        end
    end

    always @(posedge mclk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run stopped, tests still busy after %0d cycles", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // x^24 + x^23 + x^22 + x^17 + 1
    function automatic logic [23:0] lfsr_next(input logic [23:0] s);
        return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            val        = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic longint to_us(input rtc_time_t t);
        return longint'(t.sec) * 1000000 + longint'(t.usec);
    endfunction

    function automatic logic [15:0] reg_addr(input rtc_reg_e sel);
        return {cmd_addr_base[15:3], sel};
    endfunction

    task automatic next_cycle();
        @(posedge mclk);
        #1;                         // drive and sample point
    endtask

    task automatic report_mismatch(input string sig, input longint got, input longint exp);
        $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, sig, got, exp);
        err_count++;
    endtask

    task automatic out_of_range(input string sig, input longint got, input longint lo,
                                input longint hi);
        $display("CHECK FAILED at %0t: %s is %0d, expected %0d to %0d", $time, sig, got, lo, hi);
        err_count++;
    endtask

    task automatic close_test(input string name, input int start_errs);
        test_count++;
        if (err_count == start_errs) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, err_count - start_errs);
        end
    endtask

    `include "rtc_tb_tests.svh"

    initial begin
        mclk         = 1'b0;
        refclk       = 1'b0;
        rst          = 1'b1;
        cmd_ad       = '0;
        cmd_stb      = 1'b0;
        event_in     = '0;
        out_credit   = 1'b0;
        owed_credits = 0;
        hold_credit  = 1'b0;
        lfsr_state   = 24'd93845;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        cycle_cnt    = 0;
        repeat (4) @(posedge mclk);
        #1 rst = 1'b0;
        after_reset_idle();
        set_time_rollover();
        rate_correction();
        event_stamping();
        sink_back_pressure();
        round_robin_drain();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verif
design/rtc_pkg.sv
design/cmd_deser.sv
design/rtc_core.sv
design/event_stamper.sv
design/stamp_merger.sv
design/rtc_subsys_top.sv
verif/rtc_tb.sv
